//--- verilog/tpl_adc_pkg.sv
// Sizes, pattern-select and sync-state enums, and link beat, sample and format structs
`default_nettype none

package tpl_adc_pkg;

  // **********************************************************
  // Link and converter sizes
  // **********************************************************

  // Fixed build of two channels on two lanes where lane c carries channel c
  localparam int NUM_CHANNELS = 2;
  localparam int NUM_LANES = 2;
  localparam int LANE_WIDTH = 32;
  localparam int OCTET_WIDTH = 8;

  // Converter resolution and the width each sample takes on the link
  localparam int CHANNEL_WIDTH = 14;
  localparam int SAMPLE_WIDTH = 16;
  localparam int TAIL_WIDTH = SAMPLE_WIDTH - CHANNEL_WIDTH;
  localparam int SAMPLES_PER_BEAT = 2;

  // Formatted data per channel and for the whole core
  localparam int CHAN_DATA_WIDTH = SAMPLES_PER_BEAT * SAMPLE_WIDTH;
  localparam int ADC_DATA_WIDTH = NUM_CHANNELS * CHAN_DATA_WIDTH;

  // Pattern monitor thresholds
  // LOCK_COUNT is counted in samples and LOSS_COUNT in beats
  localparam int LOCK_COUNT = 16;
  localparam int LOSS_COUNT = 4;
  localparam int LOCK_CNT_WIDTH = $clog2(LOCK_COUNT + 1);
  localparam int LOSS_CNT_WIDTH = $clog2(LOSS_COUNT + 1);

  // **********************************************************
  // Enums
  // **********************************************************

  // Test pattern select in a four bit field
  typedef enum logic [3:0] {
    PN_OFF  = 4'h0,
    PN_RAMP = 4'h1,
    PN_9    = 4'h2,
    PN_23   = 4'h3
  } pn_sel_e;

  // Monitor sync state
  typedef enum logic {
    SYNC_OOS    = 1'b0,
    SYNC_LOCKED = 1'b1
  } pn_sync_e;

  // **********************************************************
  // Structs
  // **********************************************************

  // One link beat with lane 0 in the low LANE_WIDTH bits
  typedef struct packed {
    logic                              valid;
    logic [NUM_LANES*LANE_WIDTH-1:0]   data;
  } link_beat_t;

  // Raw samples of one channel for one beat where element 0 is the earlier one
  typedef struct packed {
    logic                                             valid;
    logic [SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0]   sample;
  } chan_samples_t;

  // Per-channel output format controls
  typedef struct packed {
    logic enable;
    logic sign_extend;
    logic is_twos;
  } dfmt_cfg_t;

endpackage

`default_nettype wire

//--- verilog/tpl_adc_deframer.sv
// Deframer module that registers link beats and splits lane octets into per-channel samples
`default_nettype none
`timescale 1ns/10ps

module tpl_adc_deframer
  import tpl_adc_pkg::*;
(
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire link_beat_t                        link,
  output chan_samples_t [NUM_CHANNELS-1:0]       samples
);

  // **********************************************************
  // Octet reordering
  // **********************************************************

  // Samples after reordering, before the register
  logic [NUM_CHANNELS-1:0][SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0] sample_d;

  // Registered samples and the shared valid bit
  logic [NUM_CHANNELS-1:0][SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0] sample_q;
  logic                                                             valid_q;

  // Each lane carries one channel and each 16-bit word arrives MSB octet first,
  // so the two octets of every word are swapped back into place here
  always_comb begin
    logic [LANE_WIDTH-1:0]   lane;
    logic [SAMPLE_WIDTH-1:0] word;
    lane = '0;
    word = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      lane = link.data[c*LANE_WIDTH +: LANE_WIDTH];
      for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
        // Lower octet address holds the upper half of the word
        word = {lane[s*SAMPLE_WIDTH +: OCTET_WIDTH],
                lane[s*SAMPLE_WIDTH + OCTET_WIDTH +: OCTET_WIDTH]};
        // The converter value is left justified, the tail bits below it carry nothing
        sample_d[c][s] = word[SAMPLE_WIDTH-1:TAIL_WIDTH];
      end
    end
  end

  // **********************************************************
  // Output register
  // **********************************************************

  // Valid is the only control bit in this stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= link.valid;
    end
  end

  // Sample payload follows the link every cycle, valid says whether it means anything
  always_ff @(posedge clk) begin
    sample_q <= sample_d;
  end

  // All channels share the single link valid
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      samples[c].valid  = valid_q;
      samples[c].sample = sample_q[c];
    end
  end

endmodule

`default_nettype wire

//--- verilog/tpl_adc_pn_monitor.sv
// Pattern monitor module with self-synchronizing prediction and lock/out-of-sync FSM
`default_nettype none
`timescale 1ns/10ps

module tpl_adc_pn_monitor
  import tpl_adc_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire chan_samples_t   samples,
  input  wire pn_sel_e         pn_sel,
  output logic                 pn_err,
  output logic                 pn_oos
);

  // **********************************************************
  // Pattern prediction
  // **********************************************************

  // Predict one sample from the two received before it, prev1 being the closer one
  function automatic logic [CHANNEL_WIDTH-1:0] pn_next(
    input pn_sel_e                  sel,
    input logic [CHANNEL_WIDTH-1:0] prev2,
    input logic [CHANNEL_WIDTH-1:0] prev1
  );
    logic [8:0]               s9;
    logic [22:0]              s23;
    logic [CHANNEL_WIDTH-1:0] nxt;
    logic                     fb;
    s9  = prev1[8:0];
    // PN23 needs more state than one sample holds, so the older sample fills the top
    s23 = {prev2[8:0], prev1};
    nxt = '0;
    fb  = 1'b0;
    // Output bits come out MSB first, one shift per bit
    for (int i = CHANNEL_WIDTH - 1; i >= 0; i--) begin
      if (sel == PN_23) begin
        fb  = s23[22] ^ s23[17];
        s23 = {s23[21:0], fb};
      end else begin
        fb = s9[8] ^ s9[4];
        s9 = {s9[7:0], fb};
      end
      nxt[i] = fb;
    end
    if (sel == PN_RAMP) begin
      nxt = prev1 + 1'b1;
    end
    return nxt;
  endfunction

  // Previous valid beat, and whether one has been seen since reset
  logic [SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0]   last_q;
  logic                                             have_last_q;

  // Previous beat in the low half, current beat in the high half
  logic [2*SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0] hist_s;
  logic [SAMPLES_PER_BEAT-1:0]                      match_s;

  assign hist_s = {samples.sample, last_q};

  always_comb begin
    for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
      match_s[s] = have_last_q &&
                   (hist_s[SAMPLES_PER_BEAT+s] == pn_next(pn_sel,
                                                        hist_s[SAMPLES_PER_BEAT+s-2],
                                                        hist_s[SAMPLES_PER_BEAT+s-1]));
    end
  end

  // History tracks every valid beat so prediction is ready whenever a pattern is chosen
  always_ff @(posedge clk) begin
    if (samples.valid) begin
      last_q <= samples.sample;
    end
  end

  // **********************************************************
  // Sync FSM
  // **********************************************************

  pn_sync_e                  state_q, state_d;
  logic [LOCK_CNT_WIDTH-1:0] match_cnt_q, match_cnt_d;
  logic [LOSS_CNT_WIDTH-1:0] loss_cnt_q, loss_cnt_d;

  always_comb begin
    int run;
    int total;
    // Trailing run of matches in this beat, it is the whole beat if all match
    run = 0;
    for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
      run = match_s[s] ? run + 1 : 0;
    end
    total = (&match_s) ? int'(match_cnt_q) + run : run;
    state_d     = state_q;
    match_cnt_d = match_cnt_q;
    loss_cnt_d  = loss_cnt_q;
    if (pn_sel == PN_OFF) begin
      state_d     = SYNC_OOS;
      match_cnt_d = '0;
      loss_cnt_d  = '0;
    end else if (samples.valid) begin
      case (state_q)
        SYNC_OOS: begin
          if (total >= LOCK_COUNT) begin
            state_d     = SYNC_LOCKED;
            match_cnt_d = '0;
            loss_cnt_d  = '0;
          end else begin
            match_cnt_d = LOCK_CNT_WIDTH'(total);
          end
        end
        default: begin
          // One clean beat is enough to clear the loss run
          if (&match_s) begin
            loss_cnt_d = '0;
          end else if (int'(loss_cnt_q) == LOSS_COUNT - 1) begin
            state_d    = SYNC_OOS;
            loss_cnt_d = '0;
          end else begin
            loss_cnt_d = loss_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= SYNC_OOS;
      match_cnt_q <= '0;
      loss_cnt_q  <= '0;
      have_last_q <= 1'b0;
      pn_err      <= 1'b0;
    end else begin
      state_q     <= state_d;
      match_cnt_q <= match_cnt_d;
      loss_cnt_q  <= loss_cnt_d;
      have_last_q <= have_last_q | samples.valid;
      // The beat that drops lock is reported through pn_oos only
      pn_err      <= samples.valid && !(&match_s) &&
                     (state_q == SYNC_LOCKED) && (state_d == SYNC_LOCKED);
    end
  end

  // Out-of-sync comes straight from the state register
  assign pn_oos = (state_q == SYNC_OOS);

endmodule

`default_nettype wire

//--- verilog/tpl_adc_channel.sv
// Channel module with the sample data formatter and its pattern monitor
`default_nettype none
`timescale 1ns/10ps

module tpl_adc_channel
  import tpl_adc_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire chan_samples_t          samples,
  input  wire dfmt_cfg_t              dfmt_cfg,
  input  wire pn_sel_e                pn_sel,
  output logic                        fmt_valid,
  output logic [CHAN_DATA_WIDTH-1:0]  fmt_data,
  output logic                        pn_err,
  output logic                        pn_oos
);

  // **********************************************************
  // Data formatter
  // **********************************************************

  // Widen one raw sample to the output width
  function automatic logic [SAMPLE_WIDTH-1:0] format_sample(
    input dfmt_cfg_t                cfg,
    input logic [CHANNEL_WIDTH-1:0] raw
  );
    logic [CHANNEL_WIDTH-1:0] s;
    s = raw;
    // Formatting off passes the converter code through untouched
    if (!cfg.enable) begin
      return {{TAIL_WIDTH{1'b0}}, raw};
    end
    // Offset binary becomes two's complement by flipping the MSB
    if (!cfg.is_twos) begin
      s[CHANNEL_WIDTH-1] = ~s[CHANNEL_WIDTH-1];
    end
    if (cfg.sign_extend) begin
      return {{TAIL_WIDTH{s[CHANNEL_WIDTH-1]}}, s};
    end
    return {{TAIL_WIDTH{1'b0}}, s};
  endfunction

  logic [CHAN_DATA_WIDTH-1:0] fmt_d;

  // Sample 0 lands in the low word
  always_comb begin
    for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
      fmt_d[s*SAMPLE_WIDTH +: SAMPLE_WIDTH] = format_sample(dfmt_cfg, samples.sample[s]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= samples.valid;
    end
  end

  always_ff @(posedge clk) begin
    fmt_data <= fmt_d;
  end

  // **********************************************************
  // Pattern monitor
  // **********************************************************

  // The monitor sees raw samples and also takes one cycle, so status lines up with data
  tpl_adc_pn_monitor i_pn_monitor (
    .clk     (clk),
    .rst_n   (rst_n),
    .samples (samples),
    .pn_sel  (pn_sel),
    .pn_err  (pn_err),
    .pn_oos  (pn_oos)
  );

endmodule

`default_nettype wire

//--- verilog/tpl_adc_core.sv
// Top-level receive transport module joining the deframer to one channel per ADC channel
`default_nettype none
`timescale 1ns/10ps

module tpl_adc_core
  import tpl_adc_pkg::*;
(
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  // Aligned beats from the link layer, always accepted
  input  wire link_beat_t                    link,

  // Static per-channel controls
  input  wire dfmt_cfg_t [NUM_CHANNELS-1:0]  dfmt_cfg,
  input  wire pn_sel_e   [NUM_CHANNELS-1:0]  pn_sel,

  // Formatted sample stream, two cycles behind the link
  output logic [NUM_CHANNELS-1:0]            adc_valid,
  output logic [ADC_DATA_WIDTH-1:0]          adc_data,

  // Pattern status for the beat currently on adc_data
  output logic [NUM_CHANNELS-1:0]            pn_err,
  output logic [NUM_CHANNELS-1:0]            pn_oos
);

  // **********************************************************
  // Deframer
  // **********************************************************

  chan_samples_t [NUM_CHANNELS-1:0] samples_s;

  tpl_adc_deframer i_deframer (
    .clk     (clk),
    .rst_n   (rst_n),
    .link    (link),
    .samples (samples_s)
  );

  // **********************************************************
  // Channels
  // **********************************************************

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
    tpl_adc_channel i_channel (
      .clk       (clk),
      .rst_n     (rst_n),
      .samples   (samples_s[c]),
      .dfmt_cfg  (dfmt_cfg[c]),
      .pn_sel    (pn_sel[c]),
      .fmt_valid (adc_valid[c]),
      .fmt_data  (adc_data[c*CHAN_DATA_WIDTH +: CHAN_DATA_WIDTH]),
      .pn_err    (pn_err[c]),
      .pn_oos    (pn_oos[c])
    );
  end

endmodule

`default_nettype wire

//--- tests/tpl_adc_core_asserts.sv
// Concurrent assertions on the transport core's valid timing and pattern status
`default_nettype none
`timescale 1ns/10ps

module tpl_adc_core_asserts
  import tpl_adc_pkg::*;
(
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire logic                    link_valid,
  input wire logic [NUM_CHANNELS-1:0] adc_valid,
  input wire logic [NUM_CHANNELS-1:0] pn_err,
  input wire logic [NUM_CHANNELS-1:0] pn_oos
);

  // Deframer and channel each add one register stage
  a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
    adc_valid == {NUM_CHANNELS{$past(link_valid, 2)}})
    else $error("adc_valid does not follow link valid by two cycles");

  // An error is only flagged while the monitor holds lock
  a_err_only_locked: assert property (@(posedge clk) disable iff (!rst_n)
    (pn_err & pn_oos) == '0)
    else $error("pn_err raised while pn_oos is high");

  a_oos_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (pn_oos == '1))
    else $error("pn_oos is not high right after reset");

endmodule

bind tpl_adc_core tpl_adc_core_asserts i_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .link_valid (link.valid),
  .adc_valid  (adc_valid),
  .pn_err     (pn_err),
  .pn_oos     (pn_oos)
);

`default_nettype wire

//--- tests/tb_tpl_adc_core.sv
// Testbench with clock, reset, reference models, directed tests, timeout and summary
`default_nettype none
`timescale 1ns/10ps

module tb_tpl_adc_core
  import tpl_adc_pkg::*;
();

  // About 600 cycles of traffic and draining leave a wide margin below this limit
  localparam int TIMEOUT_CYCLES = 4000;

  typedef logic [NUM_CHANNELS-1:0][SAMPLES_PER_BEAT-1:0][CHANNEL_WIDTH-1:0] beat_samples_t;

  // One expected output beat that is checked in the cycle given by due
  typedef struct packed {
    int                         due;
    logic                       valid;
    logic [ADC_DATA_WIDTH-1:0]  data;
    logic [NUM_CHANNELS-1:0]    err;
    logic [NUM_CHANNELS-1:0]    oos;
  } expect_t;

  logic                              clk;
  logic                              rst_n;
  link_beat_t                        link;
  dfmt_cfg_t [NUM_CHANNELS-1:0]      dfmt_cfg;
  pn_sel_e   [NUM_CHANNELS-1:0]      pn_sel;
  logic [NUM_CHANNELS-1:0]           adc_valid;
  logic [ADC_DATA_WIDTH-1:0]         adc_data;
  logic [NUM_CHANNELS-1:0]           pn_err;
  logic [NUM_CHANNELS-1:0]           pn_oos;

  expect_t exp_q[$];
  int      cyc = 0;
  int      errors = 0;
  int      err_pulses [NUM_CHANNELS];

  // Sync model state whose history follows every valid beat
  logic [NUM_CHANNELS-1:0][CHANNEL_WIDTH-1:0] m_prev1, m_prev2;
  logic                                       m_have;
  pn_sync_e                                   m_state [NUM_CHANNELS];
  int                                         m_run [NUM_CHANNELS];
  int                                         m_loss [NUM_CHANNELS];

  // Stimulus generator state where PN_OFF means random samples
  pn_sel_e                                    gen_pat [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0][CHANNEL_WIDTH-1:0] g_prev1, g_prev2;

  tpl_adc_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .link      (link),
    .dfmt_cfg  (dfmt_cfg),
    .pn_sel    (pn_sel),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // **********************************************************
  // Reference models
  // **********************************************************

  function automatic logic [SAMPLE_WIDTH-1:0] expected_format(
    input dfmt_cfg_t                cfg,
    input logic [CHANNEL_WIDTH-1:0] raw
  );
    logic [CHANNEL_WIDTH-1:0] v;
    logic                     ext;
    v = raw;
    if (cfg.enable && !cfg.is_twos) begin
      v[CHANNEL_WIDTH-1] = ~v[CHANNEL_WIDTH-1];
    end
    ext = cfg.enable && cfg.sign_extend && v[CHANNEL_WIDTH-1];
    return {{TAIL_WIDTH{ext}}, v};
  endfunction

  // Next sample of a pattern from the two samples older and newer that precede it
  function automatic logic [CHANNEL_WIDTH-1:0] next_pattern_sample(
    input pn_sel_e                  sel,
    input logic [CHANNEL_WIDTH-1:0] older,
    input logic [CHANNEL_WIDTH-1:0] newer
  );
    logic [22:0]              lfsr;
    logic [CHANNEL_WIDTH-1:0] out;
    logic                     fb;
    int                       hi;
    int                       lo;
    if (sel == PN_RAMP) begin
      return newer + 1'b1;
    end
    out = '0;
    // Tap positions are the polynomial exponents counted from bit 0
    lfsr = (sel == PN_9) ? {14'b0, newer[8:0]} : {older[8:0], newer};
    hi = (sel == PN_9) ? 8 : 22;
    lo = (sel == PN_9) ? 4 : 17;
    for (int i = 0; i < CHANNEL_WIDTH; i++) begin
      fb = lfsr[hi] ^ lfsr[lo];
      lfsr = {lfsr[21:0], fb};
      out = {out[CHANNEL_WIDTH-2:0], fb};
    end
    return out;
  endfunction

  // Each sample becomes a 16-bit word with its upper octet at the lower octet address
  function automatic logic [NUM_LANES*LANE_WIDTH-1:0] pack_lanes(
    input beat_samples_t smp,
    input logic [7:0]    tails
  );
    logic [NUM_LANES*LANE_WIDTH-1:0] d;
    logic [SAMPLE_WIDTH-1:0]         word;
    d = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
        word = {smp[c][s], tails[(2*c+s)*TAIL_WIDTH +: TAIL_WIDTH]};
        d[c*LANE_WIDTH + s*SAMPLE_WIDTH +: 8] = word[15:8];
        d[c*LANE_WIDTH + s*SAMPLE_WIDTH + 8 +: 8] = word[7:0];
      end
    end
    return d;
  endfunction

  // Advances the sync model by one beat and returns the expected status
  function automatic void model_beat(
    input  logic                    valid,
    input  beat_samples_t           smp,
    output logic [NUM_CHANNELS-1:0] err,
    output logic [NUM_CHANNELS-1:0] oos
  );
    logic m0;
    logic m1;
    err = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      m0 = m_have && (smp[c][0] == next_pattern_sample(pn_sel[c], m_prev2[c], m_prev1[c]));
      m1 = m_have && (smp[c][1] == next_pattern_sample(pn_sel[c], m_prev1[c], smp[c][0]));
      if (pn_sel[c] == PN_OFF) begin
        m_state[c] = SYNC_OOS;
        m_run[c] = 0;
        m_loss[c] = 0;
      end else if (valid && m_state[c] == SYNC_OOS) begin
        // A mismatch restarts the run of consecutive matching samples
        m_run[c] = m1 ? (m0 ? m_run[c] + 2 : 1) : 0;
        if (m_run[c] >= LOCK_COUNT) begin
          m_state[c] = SYNC_LOCKED;
          m_run[c] = 0;
        end
      end else if (valid) begin
        if (m0 && m1) begin
          m_loss[c] = 0;
        end else if (m_loss[c] == LOSS_COUNT - 1) begin
          // Losing lock shows on pn_oos and not on pn_err
          m_state[c] = SYNC_OOS;
          m_loss[c] = 0;
        end else begin
          m_loss[c]++;
          err[c] = 1'b1;
        end
      end
      oos[c] = (m_state[c] == SYNC_OOS);
      if (valid) begin
        m_prev2[c] = smp[c][0];
        m_prev1[c] = smp[c][1];
      end
    end
    m_have = m_have | valid;
  endfunction

  // **********************************************************
  // Driving and checking
  // **********************************************************

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // Sends one beat where corrupt flips a bit of sample 0 on the marked channels
  task automatic send_beat(input logic valid, input logic [NUM_CHANNELS-1:0] corrupt);
    beat_samples_t           smp;
    logic [NUM_CHANNELS-1:0] err;
    logic [NUM_CHANNELS-1:0] oos;
    expect_t                 e;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
        smp[c][s] = 14'($urandom());
        if (valid && gen_pat[c] != PN_OFF) begin
          smp[c][s] = next_pattern_sample(gen_pat[c], g_prev2[c], g_prev1[c]);
        end
        if (valid) begin
          g_prev2[c] = g_prev1[c];
          g_prev1[c] = smp[c][s];
        end
      end
      if (corrupt[c]) begin
        smp[c][0] = smp[c][0] ^ 14'h1;
      end
    end
    @(posedge clk);
    #1;
    link.valid = valid;
    link.data = pack_lanes(smp, 8'($urandom()));
    model_beat(valid, smp, err, oos);
    e.due = cyc + 2;
    e.valid = valid;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < SAMPLES_PER_BEAT; s++) begin
        e.data[c*CHAN_DATA_WIDTH + s*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
          expected_format(dfmt_cfg[c], smp[c][s]);
      end
    end
    e.err = err;
    e.oos = oos;
    exp_q.push_back(e);
  endtask

  // Stops traffic and returns at a falling edge once every beat is checked
  task automatic drain();
    @(posedge clk);
    #1;
    link.valid = 1'b0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
    end
  endtask

  task automatic apply_controls(input dfmt_cfg_t cfg0, input dfmt_cfg_t cfg1,
                                input pn_sel_e sel0, input pn_sel_e sel1);
    drain();
    dfmt_cfg[0] = cfg0;
    dfmt_cfg[1] = cfg1;
    pn_sel[0] = sel0;
    pn_sel[1] = sel1;
    err_pulses = '{default: 0};
  endtask

  // Outputs are stable at the falling edge halfway between input changes
  always @(negedge clk) begin : check_outputs
    expect_t e;
    if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      assert (adc_valid == {NUM_CHANNELS{e.valid}})
        else report_mismatch($sformatf("adc_valid %b, expected %b", adc_valid, e.valid));
      if (e.valid) begin
        assert (adc_data == e.data)
          else report_mismatch($sformatf("adc_data %h, expected %h", adc_data, e.data));
      end
      assert (pn_err == e.err)
        else report_mismatch($sformatf("pn_err %b, expected %b", pn_err, e.err));
      assert (pn_oos == e.oos)
        else report_mismatch($sformatf("pn_oos %b, expected %b", pn_oos, e.oos));
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        err_pulses[c] += int'(pn_err[c]);
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // **********************************************************
  // Directed tests
  // **********************************************************

  task automatic reset_and_format_sweep();
    assert (adc_valid == '0 && pn_err == '0 && pn_oos == '1)
      else report_mismatch("outputs after reset are not idle and out of sync");
    // Channel 1 runs the mirrored setting so both see every combination
    for (int k = 0; k < 8; k++) begin
      apply_controls(3'(k), 3'(7 - k), PN_OFF, PN_OFF);
      repeat (25) send_beat(1'b1, '0);
    end
    drain();
  endtask

  task automatic valid_gap_traffic();
    apply_controls(3'b110, 3'b101, PN_OFF, PN_OFF);
    repeat (200) send_beat($urandom_range(3) != 0, '0);
    drain();
  endtask

  task automatic ramp_lock_and_loss();
    gen_pat[0] = PN_RAMP;
    gen_pat[1] = PN_RAMP;
    apply_controls(3'b111, 3'b100, PN_RAMP, PN_RAMP);
    // The first beat may only match its second sample
    repeat (LOCK_COUNT / SAMPLES_PER_BEAT + 1) send_beat(1'b1, '0);
    drain();
    assert (pn_oos == '0) else report_mismatch("ramp did not lock");
    send_beat(1'b1, 2'b11);
    repeat (4) send_beat(1'b1, '0);
    drain();
    assert (err_pulses[0] == 1 && err_pulses[1] == 1 && pn_oos == '0)
      else report_mismatch("single corrupted beat not flagged exactly once");
    repeat (LOSS_COUNT) send_beat(1'b1, 2'b11);
    drain();
    assert (pn_oos == '1) else report_mismatch("lock kept after repeated errors");
  endtask

  task automatic prbs_lock_and_isolation();
    gen_pat[0] = PN_9;
    gen_pat[1] = PN_23;
    apply_controls(3'b110, 3'b111, PN_9, PN_23);
    repeat (12) send_beat(1'b1, '0);
    drain();
    assert (pn_oos == '0) else report_mismatch("PN9 or PN23 did not lock");
    err_pulses = '{default: 0};
    send_beat(1'b1, 2'b10);
    repeat (4) send_beat(1'b1, '0);
    drain();
    assert (err_pulses[0] == 0 && err_pulses[1] > 0 && pn_oos == '0)
      else report_mismatch("error on channel 1 not isolated to channel 1");
  endtask

  task automatic pattern_off_hold();
    gen_pat[0] = PN_RAMP;
    gen_pat[1] = PN_RAMP;
    apply_controls(3'b000, 3'b111, PN_OFF, PN_OFF);
    repeat (24) send_beat(1'b1, '0);
    drain();
    assert (err_pulses[0] == 0 && err_pulses[1] == 0 && pn_oos == '1)
      else report_mismatch("monitor active with pattern checking off");
  endtask

  initial begin
    void'($urandom(29));
    rst_n = 1'b0;
    link = '0;
    dfmt_cfg = '0;
    pn_sel[0] = PN_OFF;
    pn_sel[1] = PN_OFF;
    m_have = 1'b0;
    m_prev1 = '0;
    m_prev2 = '0;
    g_prev1 = '0;
    g_prev2 = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      m_state[c] = SYNC_OOS;
      m_run[c] = 0;
      m_loss[c] = 0;
      gen_pat[c] = PN_OFF;
      err_pulses[c] = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_and_format_sweep();
    valid_gap_traffic();
    ramp_lock_and_loss();
    prbs_lock_and_isolation();
    pattern_off_hold();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/tpl_adc_pkg.sv
verilog/tpl_adc_deframer.sv
verilog/tpl_adc_pn_monitor.sv
verilog/tpl_adc_channel.sv
verilog/tpl_adc_core.sv
tests/tpl_adc_core_asserts.sv
tests/tb_tpl_adc_core.sv

//--- Makefile
TOP = tb_tpl_adc_core
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	! grep -q "TESTBENCH FAILED" $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
